/* hdl/ethRtPkg.sv */
package ethRtPkg;

    // ----------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------
    typedef logic [15:0] ethWord_t;   // One frame word, upper byte first on the wire
    typedef logic [11:0] byteCnt_t;   // Byte count of a frame
    typedef logic [11:0] wordCnt_t;   // Word count of a frame
    typedef logic [15:0] timeCnt_t;   // Cycle count for timing

    // ----------------------------------------
    // Streams
    // ----------------------------------------

    // Frame word as it travels between blocks
    typedef struct packed {
        ethWord_t data;
        logic     last;               // Final word of the frame
        logic     oddByte;            // Only data[15:8] valid on the final word
    } ethStream_t;

    // Word from the PHY receive side
    typedef struct packed {
        ethStream_t stream;
        logic       crcBad;           // Frame failed CRC, sampled with last
    } phyRx_t;

    // Frame descriptor, one per received frame
    typedef struct packed {
        logic     flush;              // Drop the frame instead of forwarding
        logic     [7:0] firstByte;    // Upper byte of word 0
        byteCnt_t byteCount;
    } rxInfo_t;

    // ----------------------------------------
    // Switch engine FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE,                      // Pick next job
        ST_RECEIVE,                   // Stream good frame to host
        ST_FLUSH,                     // Drain bad frame silently
        ST_SEND                       // Host frame into send FIFO
    } switchState_t;

endpackage

/* hdl/ethSyncFifo.sv */
`timescale 1ns/1ps

// Show-ahead synchronous FIFO, head entry always on dout
module ethSyncFifo #(
    parameter int WIDTH = 18,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];    // Storage
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;          // Occupancy
    logic             doPush;
    logic             doPop;

    // Pointer advance with wrap, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPush = push & ~full;     // Push on full is dropped
    assign doPop  = pop & ~empty;     // Pop on empty is dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop)  rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= din;
        end
    end

    // Head entry, new data shows one cycle after push
    assign dout  = mem[rdPtr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule

/* hdl/ethRxFramer.sv */
`timescale 1ns/1ps

// Per-port receive framer
// Words go to the data FIFO, one descriptor per frame to the info FIFO
module ethRxFramer import ethRtPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  phyRx_t     phyRx,
    input  logic       phyRxValid,
    input  logic       dataFull,
    input  logic       infoFull,
    output logic       phyRxReady,
    output logic       dataPush,
    output ethStream_t dataWord,
    output logic       infoPush,
    output rxInfo_t    info
);

    logic     rxEnable;               // Set once reset is released
    logic     rxXfer;                 // Word accepted this cycle
    logic     firstWord;              // Current word is word 0 of a frame
    byteCnt_t byteCnt;                // Bytes accepted so far in this frame
    byteCnt_t byteCntNext;
    logic     [7:0] firstByteQ;       // Upper byte of word 0, held for the descriptor

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // Both FIFOs must have room, so the descriptor of a last word always fits
    assign phyRxReady = rxEnable & ~dataFull & ~infoFull;
    assign rxXfer     = phyRxValid & phyRxReady;
    assign firstWord  = (byteCnt == '0);

    always_ff @(posedge clk) begin
        if (rst) rxEnable <= 1'b0;
        else     rxEnable <= 1'b1;
    end

    // ----------------------------------------
    // Byte count and first byte
    // ----------------------------------------

    // Two bytes per word, one on an odd final word
    assign byteCntNext = byteCnt + (phyRx.stream.oddByte ? byteCnt_t'(1) : byteCnt_t'(2));

    always_ff @(posedge clk) begin
        if (rst) begin
            byteCnt <= '0;
        end else if (rxXfer) begin
            if (phyRx.stream.last) byteCnt <= '0;      // Ready for next frame
            else                   byteCnt <= byteCntNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rxXfer && firstWord) begin
            firstByteQ <= phyRx.stream.data[15:8];
        end
    end

    // ----------------------------------------
    // FIFO writes, same cycle as the transfer
    // ----------------------------------------
    assign dataPush = rxXfer;
    assign dataWord = phyRx.stream;

    assign infoPush       = rxXfer & phyRx.stream.last;
    assign info.flush     = phyRx.crcBad;
    assign info.firstByte = firstWord ? phyRx.stream.data[15:8] : firstByteQ;  // Single-word frame
    assign info.byteCount = byteCntNext;

endmodule

/* hdl/ethSwitchRt.sv */
`timescale 1ns/1ps

// Switch engine, serves one port at a time
// Receive frames go to the host, host frames go to the send FIFO of curPort
module ethSwitchRt import ethRtPkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Receive descriptors
    input  rxInfo_t    rxInfo0,
    input  rxInfo_t    rxInfo1,
    input  logic [1:0] infoEmpty,
    output logic [1:0] infoPop,
    // Receive data
    input  ethStream_t rxData0,
    input  ethStream_t rxData1,
    input  logic [1:0] dataEmpty,
    output logic [1:0] dataPop,
    // Host side
    output ethStream_t hostRx,
    output logic       hostRxValid,
    input  logic       hostRxReady,
    input  ethStream_t hostTx,
    input  logic       hostTxValid,
    output logic       hostTxReady,
    // Send FIFOs
    input  logic [1:0] sendFull,
    output logic [1:0] sendPush,
    output ethStream_t sendWord,
    // Status
    output logic       curPort,       // 0 -> port 0, 1 -> port 1
    output timeCnt_t   timeReceive    // Cycles from descriptor pop to final host word
);

    switchState_t state;
    rxInfo_t      rxInfoCur;          // Descriptor head of curPort
    ethStream_t   rxDataCur;          // Data head of curPort
    wordCnt_t     rxWords;            // Words in the current frame
    wordCnt_t     wordCnt;            // Words popped so far
    timeCnt_t     timeNow;            // Running time since descriptor pop
    logic         lastWord;           // Data head is the final word of the frame
    logic         wordPop;            // A data word leaves the FIFO this cycle

    // Words from bytes, rounded up, computed wide so 4095 bytes does not wrap
    function automatic wordCnt_t wordsOf(input byteCnt_t bytes);
        logic [12:0] sum;
        sum = {1'b0, bytes} + 13'd1;
        return wordCnt_t'(sum >> 1);
    endfunction

    // ----------------------------------------
    // Port select
    // ----------------------------------------
    assign rxInfoCur = curPort ? rxInfo1 : rxInfo0;
    assign rxDataCur = curPort ? rxData1 : rxData0;
    assign lastWord  = (wordCnt == wordCnt_t'(rxWords - 1'b1));

    // Host receive stream, last comes from our own count
    always_comb begin
        hostRx.data    = rxDataCur.data;
        hostRx.oddByte = rxDataCur.oddByte;
        hostRx.last    = lastWord;
    end

    assign sendWord = hostTx;         // Send FIFO of curPort takes host words as they are

    // ----------------------------------------
    // Handshakes and FIFO strobes
    // ----------------------------------------
    always_comb begin
        infoPop     = '0;
        dataPop     = '0;
        sendPush    = '0;
        hostRxValid = 1'b0;
        hostTxReady = 1'b0;
        case (state)
            ST_IDLE: begin
                // Sends win, descriptor only popped when no send is pending
                if (!hostTxValid && !infoEmpty[curPort]) infoPop[curPort] = 1'b1;
            end
            ST_RECEIVE: begin
                hostRxValid      = ~dataEmpty[curPort];
                dataPop[curPort] = hostRxValid & hostRxReady;
            end
            ST_FLUSH: begin
                dataPop[curPort] = ~dataEmpty[curPort];   // One word per cycle
            end
            ST_SEND: begin
                hostTxReady       = ~sendFull[curPort];
                sendPush[curPort] = hostTxValid & hostTxReady;
            end
            default: ;
        endcase
    end

    assign wordPop = |dataPop;

    // ----------------------------------------
    // Switch FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            curPort     <= 1'b0;
            timeReceive <= '0;
            timeNow     <= '0;
            wordCnt     <= '0;
            rxWords     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    timeNow <= timeCnt_t'(1);   // Pop cycle counts as the first
                    wordCnt <= '0;
                    if (hostTxValid) begin
                        state <= ST_SEND;
                    end else if (!infoEmpty[curPort]) begin
                        rxWords <= wordsOf(rxInfoCur.byteCount);
                        state   <= rxInfoCur.flush ? ST_FLUSH : ST_RECEIVE;
                    end else if (!infoEmpty[~curPort]) begin
                        // Only the other port has a frame, two ports only
                        curPort <= ~curPort;
                    end
                end

                ST_RECEIVE: begin
                    timeNow <= timeNow + 1'b1;
                    if (wordPop) begin
                        if (lastWord) begin
                            timeReceive <= timeNow + 1'b1;   // Include the final transfer
                            state       <= ST_IDLE;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                end

                ST_FLUSH: begin
                    timeNow <= timeNow + 1'b1;
                    if (wordPop) begin
                        if (lastWord) state <= ST_IDLE;   // timeReceive untouched
                        else          wordCnt <= wordCnt + 1'b1;
                    end
                end

                ST_SEND: begin
                    timeNow <= timeNow + 1'b1;
                    if (sendPush[curPort] && hostTx.last) begin
                        state <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* hdl/ethSwitchTop.sv */
`timescale 1ns/1ps

// Two-port switch slice: framers, receive and send FIFOs, switch engine
module ethSwitchTop import ethRtPkg::*; #(
    parameter int DATA_DEPTH = 512,   // Receive data FIFO, words
    parameter int INFO_DEPTH = 16,    // Receive descriptor FIFO, frames
    parameter int SEND_DEPTH = 512    // Send FIFO, words
) (
    input  logic       clk,
    input  logic       rst,
    // PHY receive
    input  phyRx_t     phyRx0,
    input  phyRx_t     phyRx1,
    input  logic       phyRx0Valid,
    input  logic       phyRx1Valid,
    output logic       phyRx0Ready,
    output logic       phyRx1Ready,
    // Host
    output ethStream_t hostRx,
    output logic       hostRxValid,
    input  logic       hostRxReady,
    input  ethStream_t hostTx,
    input  logic       hostTxValid,
    output logic       hostTxReady,
    // PHY send
    output ethStream_t phyTx0,
    output ethStream_t phyTx1,
    output logic       phyTx0Valid,
    output logic       phyTx1Valid,
    input  logic       phyTx0Ready,
    input  logic       phyTx1Ready,
    // Status
    output logic       curPort,
    output timeCnt_t   timeReceive
);

    localparam int STREAM_W = $bits(ethStream_t);
    localparam int INFO_W   = $bits(rxInfo_t);

    phyRx_t     phyRxVec  [2];
    logic [1:0] phyRxValidVec, phyRxReadyVec;
    logic [1:0] phyTxReadyVec, sendEmpty;
    ethStream_t dataWord  [2];        // Framer to data FIFO
    ethStream_t dataDout  [2];        // Data FIFO heads
    ethStream_t sendDout  [2];        // Send FIFO heads
    rxInfo_t    info      [2];        // Framer to info FIFO
    rxInfo_t    infoDout  [2];        // Info FIFO heads
    ethStream_t sendWord;
    logic [1:0] dataPush, dataFull, dataEmpty, dataPop;
    logic [1:0] infoPush, infoFull, infoEmpty, infoPop;
    logic [1:0] sendPush, sendFull;

    assign phyRxVec[0]   = phyRx0;
    assign phyRxVec[1]   = phyRx1;
    assign phyRxValidVec = {phyRx1Valid, phyRx0Valid};
    assign {phyRx1Ready, phyRx0Ready} = phyRxReadyVec;
    assign phyTxReadyVec = {phyTx1Ready, phyTx0Ready};
    assign phyTx0        = sendDout[0];
    assign phyTx1        = sendDout[1];
    assign phyTx0Valid   = ~sendEmpty[0];   // Head present means valid
    assign phyTx1Valid   = ~sendEmpty[1];

    // ----------------------------------------
    // Per-port framer and FIFOs
    // ----------------------------------------
    for (genvar p = 0; p < 2; p++) begin : g_port
        ethRxFramer i_ethRxFramer (
            .clk, .rst,
            .phyRx(phyRxVec[p]), .phyRxValid(phyRxValidVec[p]),
            .dataFull(dataFull[p]), .infoFull(infoFull[p]),
            .phyRxReady(phyRxReadyVec[p]),
            .dataPush(dataPush[p]), .dataWord(dataWord[p]),
            .infoPush(infoPush[p]), .info(info[p])
        );

        ethSyncFifo #(.WIDTH(STREAM_W), .DEPTH(DATA_DEPTH)) i_dataFifo (
            .clk, .rst, .push(dataPush[p]), .din(dataWord[p]), .pop(dataPop[p]),
            .dout(dataDout[p]), .full(dataFull[p]), .empty(dataEmpty[p])
        );

        ethSyncFifo #(.WIDTH(INFO_W), .DEPTH(INFO_DEPTH)) i_infoFifo (
            .clk, .rst, .push(infoPush[p]), .din(info[p]), .pop(infoPop[p]),
            .dout(infoDout[p]), .full(infoFull[p]), .empty(infoEmpty[p])
        );

        // PHY takes a word when it is ready and a word is there
        ethSyncFifo #(.WIDTH(STREAM_W), .DEPTH(SEND_DEPTH)) i_sendFifo (
            .clk, .rst, .push(sendPush[p]), .din(sendWord),
            .pop(phyTxReadyVec[p] & ~sendEmpty[p]),
            .dout(sendDout[p]), .full(sendFull[p]), .empty(sendEmpty[p])
        );
    end

    // ----------------------------------------
    // Switch engine
    // ----------------------------------------
    ethSwitchRt i_ethSwitchRt (
        .clk, .rst,
        .rxInfo0(infoDout[0]), .rxInfo1(infoDout[1]),
        .infoEmpty, .infoPop,
        .rxData0(dataDout[0]), .rxData1(dataDout[1]),
        .dataEmpty, .dataPop,
        .hostRx, .hostRxValid, .hostRxReady,
        .hostTx, .hostTxValid, .hostTxReady,
        .sendFull, .sendPush, .sendWord,
        .curPort, .timeReceive
    );

endmodule

/* verification/ethSwitchTb_sva.sv */
`timescale 1ns/1ps

// Protocol and state checks on the switch engine
module ethSwitchTbSva import ethRtPkg::*; (
    input logic         clk,
    input logic         rst,
    input ethStream_t   hostRx,
    input logic         hostRxValid,
    input logic         hostRxReady,
    input logic [1:0]   infoPop,
    input logic [1:0]   infoEmpty,
    input logic [1:0]   dataPop,
    input logic [1:0]   dataEmpty,
    input switchState_t state
);

    int failCount = 0;                // Failed assertions so far

    // ----------------------------------------
    // Host receive handshake
    // ----------------------------------------

    // Stalled word must stay put until taken
    property hostRxHold;
        @(posedge clk) disable iff (rst)
        (hostRxValid && !hostRxReady) |=> (hostRxValid && $stable(hostRx));
    endproperty
    assertHostRxHold: assert property (hostRxHold)
        else begin
            failCount++;
            $error("hostRx changed or dropped valid while stalled");
        end

    // ----------------------------------------
    // FIFO pops and FSM
    // ----------------------------------------
    assertInfoPop: assert property (@(posedge clk) disable iff (rst) (infoPop & infoEmpty) == '0)
        else begin
            failCount++;
            $error("descriptor pop on empty info FIFO");
        end

    assertDataPop: assert property (@(posedge clk) disable iff (rst) (dataPop & dataEmpty) == '0)
        else begin
            failCount++;
            $error("word pop on empty data FIFO");
        end

    assertState: assert property (@(posedge clk) disable iff (rst)
        state inside {ST_IDLE, ST_RECEIVE, ST_FLUSH, ST_SEND})
        else begin
            failCount++;
            $error("switch FSM in illegal state");
        end

endmodule

bind ethSwitchRt ethSwitchTbSva i_ethSwitchTbSva (
    .clk, .rst, .hostRx, .hostRxValid, .hostRxReady,
    .infoPop, .infoEmpty, .dataPop, .dataEmpty, .state
);

/* verification/ethSwitchTb.sv */
`timescale 1ns/1ps

module ethSwitchTb import ethRtPkg::*; ();

    localparam int TOTAL_WORDS = 111;                 // Sum of all frame words below
    localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 2000;

    logic       clk;
    logic       rst;
    phyRx_t     phyRx0, phyRx1;
    logic       phyRx0Valid, phyRx1Valid, phyRx0Ready, phyRx1Ready;
    ethStream_t hostRx, hostTx, phyTx0, phyTx1;
    logic       hostRxValid, hostRxReady, hostTxValid, hostTxReady;
    logic       phyTx0Valid, phyTx1Valid, phyTx0Ready, phyTx1Ready;
    logic       curPort;
    timeCnt_t   timeReceive;

    ethStream_t expRx0[$];            // Expected host words from port 0
    ethStream_t expRx1[$];            // Expected host words from port 1
    ethStream_t expTx[$];             // Expected phyTx1 words
    int         errMismatch = 0;
    int         errOther    = 0;
    int         errAssert   = 0;      // Failed bound assertions
    int         cycles      = 0;
    logic [31:0] rngState   = 32'd46;
    logic       randHostReady = 1'b0; // Random hostRx back-pressure on
    logic       randTxReady   = 1'b0; // Random phyTx1 back-pressure on
    logic       inFrame     = 1'b0;   // Host frame under way
    logic       framePort;
    int         span;                 // Cycles from first valid, running
    int         lastSpan    = 0;      // Span of the last completed frame

    ethSwitchTop i_ethSwitchTop (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;        // 8 ns period
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic rxReady(input int port);
        return port ? phyRx1Ready : phyRx0Ready;
    endfunction

    task automatic checkStream(input string name, input ethStream_t got, input ethStream_t exp);
        if (got !== exp) begin
            errMismatch++;
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkPort(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errMismatch++;
            $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Range check, timing depends on back-pressure
    task automatic checkTime(input string name, input timeCnt_t got,
                             input timeCnt_t lo, input timeCnt_t hi);
        if (got < lo || got > hi) begin
            errMismatch++;
            $display("mismatch at %0t: %s = %0d, expected %0d..%0d", $time, name, got, lo, hi);
        end
    endtask

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    // One PHY frame, good frames are queued as expected host words
    task automatic sendRx(input int port, input int nWords, input logic odd, input logic bad);
        phyRx_t w;
        for (int i = 0; i < nWords; i++) begin
            w.stream.data    = ethWord_t'(nextRand());
            w.stream.last    = (i == nWords - 1);
            w.stream.oddByte = odd && (i == nWords - 1);
            w.crcBad         = bad && (i == nWords - 1);
            if (!bad) begin
                if (port) expRx1.push_back(w.stream);
                else      expRx0.push_back(w.stream);
            end
            @(negedge clk);
            if (port) begin
                phyRx1 = w;
                phyRx1Valid = 1'b1;
            end else begin
                phyRx0 = w;
                phyRx0Valid = 1'b1;
            end
            while (!rxReady(port)) @(negedge clk);      // Taken at next rising edge
        end
        @(negedge clk);
        if (port) phyRx1Valid = 1'b0;
        else      phyRx0Valid = 1'b0;
    endtask

    task automatic sendHost(input int nWords);
        ethStream_t w;
        for (int i = 0; i < nWords; i++) begin
            w.data    = ethWord_t'(nextRand());
            w.last    = (i == nWords - 1);
            w.oddByte = 1'b0;
            expTx.push_back(w);
            @(negedge clk);
            hostTx      = w;
            hostTxValid = 1'b1;
            while (!hostTxReady) @(negedge clk);
        end
        @(negedge clk);
        hostTxValid = 1'b0;
    endtask

    task automatic waitDrained();
        while (expRx0.size() != 0 || expRx1.size() != 0 || expTx.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);                      // Let FSM settle in idle
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic testGoodPort0();
        sendRx(0, 5, 1'b0, 1'b0);
        sendRx(0, 7, 1'b1, 1'b0);                       // Odd final byte
        waitDrained();
        checkPort("curPort", curPort, 1'b0);
    endtask

    task automatic testCrcFlush();
        sendRx(0, 4, 1'b0, 1'b1);                       // Dropped silently
        sendRx(0, 6, 1'b0, 1'b0);
        waitDrained();
    endtask

    task automatic testPort1();
        sendRx(1, 8, 1'b0, 1'b0);
        waitDrained();
        checkPort("curPort", curPort, 1'b1);
    endtask

    task automatic testHostSend();
        randTxReady = 1'b1;
        sendHost(10);
        waitDrained();
        randTxReady = 1'b0;
        @(negedge clk);
        phyTx1Ready = 1'b1;
    endtask

    task automatic testRandomReady();
        randHostReady = 1'b1;
        for (int f = 0; f < 3; f++) begin
            sendRx(0, 9, 1'b0, 1'b0);
            waitDrained();
            checkTime("timeReceive", timeReceive, timeCnt_t'(9), timeCnt_t'(lastSpan + 2));
        end
        randHostReady = 1'b0;
        @(negedge clk);
        hostRxReady = 1'b1;
    endtask

    task automatic testBothPorts();
        fork
            for (int f = 0; f < 4; f++) sendRx(0, 6, f[0], 1'b0);
            for (int f = 0; f < 4; f++) sendRx(1, 5, 1'b0, 1'b0);
        join
        waitDrained();
    endtask

    // ----------------------------------------
    // Monitors and back-pressure
    // ----------------------------------------
    always @(negedge clk) begin
        if (randHostReady) hostRxReady = (nextRand() & 32'h1) != 32'h0;
        if (randTxReady)   phyTx1Ready = (nextRand() & 32'h1) != 32'h0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (hostRxValid && !inFrame) begin          // Start of a host frame
                inFrame   = 1'b1;
                framePort = curPort;
                span      = 0;
            end
            if (inFrame) span++;
            if (hostRxValid && hostRxReady) begin
                if (curPort !== framePort) begin
                    errOther++;
                    $display("Frame from port %0d interleaved with port %0d at %0t",
                             framePort, curPort, $time);
                end
                if (curPort == 1'b0 && expRx0.size() != 0)
                    checkStream("hostRx", hostRx, expRx0.pop_front());
                else if (curPort == 1'b1 && expRx1.size() != 0)
                    checkStream("hostRx", hostRx, expRx1.pop_front());
                else begin
                    errOther++;
                    $display("Unexpected hostRx word from port %0d at %0t", curPort, $time);
                end
                if (hostRx.last) begin
                    inFrame  = 1'b0;
                    lastSpan = span;
                end
            end
            if (phyTx1Valid && phyTx1Ready) begin
                if (expTx.size() != 0) checkStream("phyTx1", phyTx1, expTx.pop_front());
                else begin
                    errOther++;
                    $display("Unexpected phyTx1 word at %0t", $time);
                end
            end
            if (phyTx0Valid && phyTx0Ready) begin       // Port 0 never sends here
                errOther++;
                $display("Unexpected phyTx0 word at %0t", $time);
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, run stopped", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst         = 1'b1;
        phyRx0      = '0;
        phyRx1      = '0;
        phyRx0Valid = 1'b0;
        phyRx1Valid = 1'b0;
        hostRxReady = 1'b1;
        hostTx      = '0;
        hostTxValid = 1'b0;
        phyTx0Ready = 1'b1;
        phyTx1Ready = 1'b1;
        repeat (16) @(negedge clk);
        if (hostRxValid || hostTxReady || phyTx0Valid || phyTx1Valid ||
            phyRx0Ready || phyRx1Ready) begin
            errOther++;
            $display("Outputs not idle during reset");
        end
        checkPort("curPort", curPort, 1'b0);
        checkTime("timeReceive", timeReceive, '0, '0);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        testGoodPort0();
        testCrcFlush();
        testPort1();
        testHostSend();
        testRandomReady();
        testBothPorts();

        errAssert = i_ethSwitchTop.i_ethSwitchRt.i_ethSwitchTbSva.failCount;
        $display("Errors: %0d mismatches, %0d other, %0d assertions",
                 errMismatch, errOther, errAssert);
        if (errMismatch == 0 && errOther == 0 && errAssert == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* ethSwitchTop.f */
hdl/ethRtPkg.sv
hdl/ethSyncFifo.sv
hdl/ethRxFramer.sv
hdl/ethSwitchRt.sv
hdl/ethSwitchTop.sv
verification/ethSwitchTb_sva.sv
verification/ethSwitchTb.sv

/* Bender.yml */
package:
  name: eth_switch_rt

sources:
  - hdl/ethRtPkg.sv
  - hdl/ethSyncFifo.sv
  - hdl/ethRxFramer.sv
  - hdl/ethSwitchRt.sv
  - hdl/ethSwitchTop.sv
  - target: test
    files:
      - verification/ethSwitchTb_sva.sv
      - verification/ethSwitchTb.sv
